/* design/cpu_pkg.sv */
package cpu_pkg;

    typedef logic [15:0] word_t;     // data and instruction word
    typedef logic [2:0]  reg_addr_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [15:0] addr_t;
    typedef logic [2:0]  flags_t;    // {carry, negative, zero}

    // instruction word: opcode[15:11] rs[10:8] rd[7:5] shamt[4:0]
    typedef enum logic [4:0] {
        op_nop  = 5'd0,
        op_setc = 5'd1,
        op_not  = 5'd2,
        op_inc  = 5'd3,
        op_in   = 5'd4,
        op_out  = 5'd5,
        op_mov  = 5'd6,
        op_add  = 5'd7,
        op_sub  = 5'd8,
        op_and  = 5'd9,
        op_or   = 5'd10,
        op_shl  = 5'd11,
        op_shr  = 5'd12,
        op_ldm  = 5'd13,   // immediate in the following word
        op_ldd  = 5'd14,
        op_std  = 5'd15,
        op_jz   = 5'd16,
        op_jmp  = 5'd17
    } opcode_t;

    localparam int imem_depth = 256;
    localparam int dmem_depth = 256;
    localparam int num_regs   = 8;

    localparam int imem_aw = $clog2(imem_depth);
    localparam int dmem_aw = $clog2(dmem_depth);

    // bit positions inside flags_t
    localparam int flag_z = 0;
    localparam int flag_n = 1;
    localparam int flag_c = 2;

endpackage

/* design/fetch_stage.sv */
`timescale 1ns/1ns

module fetch_stage (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           stall,
    input  logic           jump_taken,
    input  cpu_pkg::addr_t jump_target,
    output cpu_pkg::word_t instr,
    output cpu_pkg::word_t imm,
    output cpu_pkg::addr_t instr_pc
);
    import cpu_pkg::*;

    word_t imem [imem_depth];
    addr_t pc;
    addr_t pc_inc;
    word_t cur_word;
    word_t next_word;
    logic  is_ldm;

    initial begin
        $readmemh("bench/program.hex", imem);
    end

    // both words read every cycle, second one only matters for ldm
    assign pc_inc    = pc + 16'd1;
    assign cur_word  = imem[pc[imem_aw-1:0]];
    assign next_word = imem[pc_inc[imem_aw-1:0]];
    assign is_ldm    = (cur_word[15:11] == op_ldm);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else if (jump_taken) begin
            pc <= jump_target;
        end else if (!stall) begin
            pc <= is_ldm ? pc + 16'd2 : pc_inc;   // skip over the immediate
        end
    end

    // fetch/decode register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            instr <= {op_nop, 11'd0};
        end else if (jump_taken) begin
            instr <= {op_nop, 11'd0};   // squash wrong-path fetch
        end else if (!stall) begin
            instr <= cur_word;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            imm      <= next_word;
            instr_pc <= pc;
        end
    end

    // load-use stall and taken jump come from different ops in execute
    assert property (@(posedge clk) disable iff (!arst_n)
        !(stall && jump_taken))
        else $error("stall and jump in the same cycle");

endmodule

/* design/decode_stage.sv */
`timescale 1ns/1ns

module decode_stage (
    input  logic              clk,
    input  logic              arst_n,
    input  cpu_pkg::word_t    instr,
    input  cpu_pkg::word_t    imm,
    input  logic              flush,
    input  cpu_pkg::reg_addr_t ex_rd,
    input  logic              ex_mem_read,
    input  logic              wb_we,
    input  cpu_pkg::reg_addr_t wb_rd,
    input  cpu_pkg::word_t    wb_data,
    output logic              stall,
    output cpu_pkg::opcode_t  op,
    output cpu_pkg::reg_addr_t rs,
    output cpu_pkg::reg_addr_t rd,
    output cpu_pkg::word_t    rs_val,
    output cpu_pkg::word_t    rd_val,
    output cpu_pkg::word_t    imm_q,
    output cpu_pkg::shamt_t   shamt,
    output logic              reg_we,
    output logic              mem_read,
    output logic              mem_write
);
    import cpu_pkg::*;

    word_t     regs [num_regs];
    opcode_t   op_d;
    reg_addr_t rs_d;
    reg_addr_t rd_d;
    shamt_t    shamt_d;
    word_t     rs_read;
    word_t     rd_read;
    logic      we_d;
    logic      rd_mem_d;
    logic      wr_mem_d;
    logic      uses_rs;
    logic      uses_rd;

    assign op_d    = opcode_t'(instr[15:11]);
    assign rs_d    = instr[10:8];
    assign rd_d    = instr[7:5];
    assign shamt_d = instr[4:0];

    always_ff @(posedge clk) begin
        if (wb_we) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // same-cycle write is visible to the read
    assign rs_read = (wb_we && wb_rd == rs_d) ? wb_data : regs[rs_d];
    assign rd_read = (wb_we && wb_rd == rd_d) ? wb_data : regs[rd_d];

    always_comb begin
        we_d     = 1'b0;
        rd_mem_d = 1'b0;
        wr_mem_d = 1'b0;
        uses_rs  = 1'b0;
        uses_rd  = 1'b0;
        case (op_d)
            op_not, op_inc, op_shl, op_shr: begin
                we_d    = 1'b1;
                uses_rd = 1'b1;
            end
            op_in, op_ldm: we_d = 1'b1;
            op_mov: begin
                we_d    = 1'b1;
                uses_rs = 1'b1;
            end
            op_add, op_sub, op_and, op_or: begin
                we_d    = 1'b1;
                uses_rs = 1'b1;
                uses_rd = 1'b1;
            end
            op_ldd: begin
                we_d     = 1'b1;
                rd_mem_d = 1'b1;
                uses_rs  = 1'b1;   // address
            end
            op_std: begin
                wr_mem_d = 1'b1;
                uses_rs  = 1'b1;
                uses_rd  = 1'b1;   // store data
            end
            op_out, op_jz, op_jmp: uses_rd = 1'b1;
            default: ;
        endcase
    end

    // load result not ready for the next instruction
    assign stall = ex_mem_read &&
                   ((uses_rs && ex_rd == rs_d) || (uses_rd && ex_rd == rd_d));

    // decode/execute register, bubble on flush or stall
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            op        <= op_nop;
            reg_we    <= 1'b0;
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
        end else if (flush || stall) begin
            op        <= op_nop;
            reg_we    <= 1'b0;
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
        end else begin
            op        <= op_d;
            reg_we    <= we_d;
            mem_read  <= rd_mem_d;
            mem_write <= wr_mem_d;
        end
    end

    always_ff @(posedge clk) begin
        rs     <= rs_d;
        rd     <= rd_d;
        rs_val <= rs_read;
        rd_val <= rd_read;
        imm_q  <= imm;
        shamt  <= shamt_d;
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        wb_we |-> !$isunknown(wb_rd))
        else $error("register write to an unknown index");

endmodule

/* design/execute_stage.sv */
`timescale 1ns/1ns

module execute_stage (
    input  logic               clk,
    input  logic               arst_n,
    input  cpu_pkg::opcode_t   op,
    input  cpu_pkg::reg_addr_t rs,
    input  cpu_pkg::reg_addr_t rd,
    input  cpu_pkg::word_t     rs_val,
    input  cpu_pkg::word_t     rd_val,
    input  cpu_pkg::word_t     imm_q,
    input  cpu_pkg::shamt_t    shamt,
    input  logic               reg_we,
    input  logic               mem_read,
    input  logic               mem_write,
    input  cpu_pkg::word_t     in_port,
    input  logic               wb_we,
    input  cpu_pkg::reg_addr_t wb_rd,
    input  cpu_pkg::word_t     wb_data,
    output cpu_pkg::reg_addr_t ex_rd,
    output logic               jump_taken,
    output cpu_pkg::addr_t     jump_target,
    output cpu_pkg::word_t     out_port,
    output logic               out_valid,
    output cpu_pkg::word_t     mem_result,
    output cpu_pkg::word_t     mem_store,
    output cpu_pkg::reg_addr_t mem_rd,
    output logic               mem_reg_we,
    output logic               mem_read_q,
    output logic               mem_write_q
);
    import cpu_pkg::*;

    flags_t flags;
    word_t  a;          // rs operand
    word_t  b;          // rd operand
    word_t  result;
    logic   carry_nxt;
    logic   set_zn;
    logic   set_c;

    // memory stage first, then write back, then register file
    function automatic word_t fwd(reg_addr_t idx, word_t reg_val);
        if (mem_reg_we && !mem_read_q && mem_rd == idx) begin
            return mem_result;   // a load still holds its address here
        end else if (wb_we && wb_rd == idx) begin
            return wb_data;
        end
        return reg_val;
    endfunction

    always_comb begin
        a = fwd(rs, rs_val);
        b = fwd(rd, rd_val);
    end

    always_comb begin
        result    = '0;
        carry_nxt = flags[flag_c];
        set_zn    = 1'b0;
        set_c     = 1'b0;
        case (op)
            op_setc: begin
                carry_nxt = 1'b1;
                set_c     = 1'b1;
            end
            op_not: begin
                result = ~b;
                set_zn = 1'b1;
            end
            op_inc: begin
                {carry_nxt, result} = {1'b0, b} + 17'd1;
                set_zn = 1'b1;
                set_c  = 1'b1;
            end
            op_add: begin
                {carry_nxt, result} = {1'b0, b} + {1'b0, a};
                set_zn = 1'b1;
                set_c  = 1'b1;
            end
            op_sub: begin
                {carry_nxt, result} = {1'b0, b} - {1'b0, a};   // carry is borrow
                set_zn = 1'b1;
                set_c  = 1'b1;
            end
            op_and: begin
                result = b & a;
                set_zn = 1'b1;
            end
            op_or: begin
                result = b | a;
                set_zn = 1'b1;
            end
            op_shl: begin
                {carry_nxt, result} = {1'b0, b} << shamt;   // last bit out
                set_zn = 1'b1;
                set_c  = 1'b1;
            end
            op_shr: begin
                {result, carry_nxt} = {b, 1'b0} >> shamt;
                set_zn = 1'b1;
                set_c  = 1'b1;
            end
            op_in:          result = in_port;
            op_mov:         result = a;
            op_ldm:         result = imm_q;
            op_ldd, op_std: result = a;   // data memory address
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flags <= '0;
        end else begin
            if (set_zn) begin
                flags[flag_z] <= (result == '0);
                flags[flag_n] <= result[15];
            end
            if (set_c) begin
                flags[flag_c] <= carry_nxt;
            end
            if (op == op_jz && flags[flag_z]) begin
                flags[flag_z] <= 1'b0;   // consumed by the taken jz
            end
        end
    end

    assign jump_taken  = (op == op_jmp) || (op == op_jz && flags[flag_z]);
    assign jump_target = b;
    assign ex_rd       = rd;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            out_port  <= '0;
        end else begin
            out_valid <= (op == op_out);
            if (op == op_out) begin
                out_port <= b;
            end
        end
    end

    // execute/memory register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_reg_we  <= 1'b0;
            mem_read_q  <= 1'b0;
            mem_write_q <= 1'b0;
        end else begin
            mem_reg_we  <= reg_we;
            mem_read_q  <= mem_read;
            mem_write_q <= mem_write;
        end
    end

    always_ff @(posedge clk) begin
        mem_result <= result;
        mem_store  <= b;
        mem_rd     <= rd;
    end

    // nothing behind a taken jump reaches execute
    assert property (@(posedge clk) disable iff (!arst_n)
        jump_taken |=> !jump_taken ##1 !out_valid)
        else $error("instruction behind a taken jump was not flushed");

endmodule

/* design/memory_stage.sv */
`timescale 1ns/1ns

module memory_stage (
    input  logic               clk,
    input  logic               arst_n,
    input  cpu_pkg::word_t     mem_result,
    input  cpu_pkg::word_t     mem_store,
    input  cpu_pkg::reg_addr_t mem_rd,
    input  logic               mem_reg_we,
    input  logic               mem_read_q,
    input  logic               mem_write_q,
    output logic               wb_we,
    output cpu_pkg::reg_addr_t wb_rd,
    output cpu_pkg::word_t     wb_data
);
    import cpu_pkg::*;

    word_t dmem [dmem_depth];
    word_t load_word;

    assign load_word = dmem[mem_result[dmem_aw-1:0]];   // async read

    always_ff @(posedge clk) begin
        if (mem_write_q) begin
            dmem[mem_result[dmem_aw-1:0]] <= mem_store;
        end
    end

    // memory/write-back register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_we <= 1'b0;
        end else begin
            wb_we <= mem_reg_we;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= mem_rd;
        wb_data <= mem_read_q ? load_word : mem_result;
    end

endmodule

/* design/processor.sv */
`timescale 1ns/1ns

module processor (
    input  logic           clk,
    input  logic           arst_n,
    input  cpu_pkg::word_t in_port,
    output cpu_pkg::word_t out_port,
    output logic           out_valid
);
    import cpu_pkg::*;

    // fetch <-> decode
    word_t     instr;
    word_t     imm;
    logic      stall;
    logic      jump_taken;
    addr_t     jump_target;

    // decode -> execute
    opcode_t   op;
    reg_addr_t rs;
    reg_addr_t rd;
    word_t     rs_val;
    word_t     rd_val;
    word_t     imm_q;
    shamt_t    shamt;
    logic      reg_we;
    logic      mem_read;
    logic      mem_write;
    reg_addr_t ex_rd;

    // execute -> memory
    word_t     mem_result;
    word_t     mem_store;
    reg_addr_t mem_rd;
    logic      mem_reg_we;
    logic      mem_read_q;
    logic      mem_write_q;

    // write back
    logic      wb_we;
    reg_addr_t wb_rd;
    word_t     wb_data;

    fetch_stage fetch_stage_i (
        .instr_pc (),   // debug only
        .*
    );

    decode_stage decode_stage_i (
        .flush       (jump_taken),
        .ex_mem_read (mem_read),    // load flag of the op now in execute
        .*
    );

    execute_stage execute_stage_i (.*);

    memory_stage memory_stage_i (.*);

endmodule

/* bench/processor_tb.sv */
`timescale 1ns/1ns

module processor_tb;
    import cpu_pkg::*;

    localparam string hex_file     = "bench/program.hex";
    localparam int    max_steps    = 10000;
    localparam int    reset_cycles = 16;
    localparam int    tail_cycles  = 20;   // idle cycles on the final self-jump

    logic  clk;
    logic  arst_n;
    word_t in_port;
    word_t out_port;
    logic  out_valid;

    word_t prog [imem_depth];
    word_t expected [$];
    word_t in_val;
    int    n_instr;
    int    cycle_limit;
    int    cycles;
    int    seen;
    logic  armed;

    processor processor_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s, at %0t", reason, $time);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input word_t actual, input word_t want);
        if (actual !== want) begin
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, want, actual);
            $display("TEST FAIL");
            $fatal(1, "simulation stopped");
        end
    endtask

    task automatic compare_flag(input string name, input logic actual, input logic want);
        if (actual !== want) begin
            $display("FAILED at %0t: %s expected %b, got %b", $time, name, want, actual);
            $display("TEST FAIL");
            $fatal(1, "simulation stopped");
        end
    endtask

    // sequential ISA model, one instruction per step, fills the expected queue
    // only the zero flag steers the program, so it is the only flag kept
    function automatic int run_reference(input word_t port_val);
        word_t     r [num_regs];
        word_t     dmem [dmem_depth];
        word_t     w;
        word_t     a;
        word_t     b;
        word_t     res;
        opcode_t   op;
        reg_addr_t rs;
        reg_addr_t rd;
        shamt_t    sh;
        addr_t     pc;
        addr_t     next_pc;
        logic      z;
        logic      alu;
        logic      halt;
        int        steps;

        pc    = '0;
        z     = 1'b0;
        halt  = 1'b0;
        steps = 0;
        expected.delete();
        while (!halt && steps < max_steps) begin
            w       = prog[pc];
            op      = opcode_t'(w[15:11]);
            rs      = w[10:8];
            rd      = w[7:5];
            sh      = w[4:0];
            a       = r[rs];
            b       = r[rd];
            res     = '0;
            alu     = 1'b0;
            next_pc = pc + 16'd1;
            steps   = steps + 1;
            case (op)
                op_not: begin
                    res = ~b;
                    alu = 1'b1;
                end
                op_inc: begin
                    res = b + 16'd1;
                    alu = 1'b1;
                end
                op_add: begin
                    res = b + a;
                    alu = 1'b1;
                end
                op_sub: begin
                    res = b - a;
                    alu = 1'b1;
                end
                op_and: begin
                    res = b & a;
                    alu = 1'b1;
                end
                op_or: begin
                    res = b | a;
                    alu = 1'b1;
                end
                op_shl: begin
                    res = b << sh;
                    alu = 1'b1;
                end
                op_shr: begin
                    res = b >> sh;
                    alu = 1'b1;
                end
                op_in:  r[rd] = port_val;
                op_mov: r[rd] = a;
                op_ldm: begin
                    r[rd]   = prog[pc + 16'd1];
                    next_pc = pc + 16'd2;
                end
                op_ldd: r[rd] = dmem[a[dmem_aw-1:0]];
                op_std: dmem[a[dmem_aw-1:0]] = b;
                op_out: expected.push_back(b);
                op_jz: begin
                    if (z) begin
                        z       = 1'b0;
                        next_pc = b;
                    end
                end
                op_jmp: begin
                    halt    = (b == pc);   // parked on itself
                    next_pc = b;
                end
                default: ;
            endcase
            if (alu) begin
                r[rd] = res;
                z     = (res == '0);
            end
            pc = next_pc;
        end
        return steps;
    endfunction

    initial begin
        arst_n  = 1'b0;
        in_port = '0;
        armed   = 1'b0;
        cycles  = 0;
        seen    = 0;
        void'($urandom(32'hfda03ee2));
        in_val = word_t'($urandom());
        $readmemh(hex_file, prog);
        n_instr = run_reference(in_val);
        if (n_instr >= max_steps) begin
            abort_run("reference model never reached a self-jump");
        end
        cycle_limit = reset_cycles + 4 * n_instr + 50;
        @(posedge clk);
        armed = 1'b1;   // first rising edge has reset the flops
        @(negedge clk);
        in_port = in_val;
        repeat (reset_cycles - 1) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        while (seen < expected.size()) begin
            @(posedge clk);
        end
        repeat (tail_cycles) @(posedge clk);   // any stray out shows up here
        $display("TEST PASS");
        $finish;
    end

    // outputs settle after the rising edge, sampled on the falling one
    always @(negedge clk) begin
        if (armed) begin
            cycles = cycles + 1;
            if (cycles > cycle_limit) begin
                abort_run("timeout, the expected outputs did not all appear");
            end else if (!arst_n) begin
                compare_flag("out_valid", out_valid, 1'b0);
            end else if (out_valid && seen >= expected.size()) begin
                abort_run("out_valid pulsed with no output left to expect");
            end else if (out_valid) begin
                check_word("out_port", out_port, expected[seen]);
                seen = seen + 1;
            end
        end
    end

endmodule

/* bench/program.hex */
// one 16-bit instruction or immediate word per entry, from address 0
// word layout: opcode[15:11] rs[10:8] rd[7:5] shamt[4:0], ldm immediate in the next word
// 0: ldm r1,5  ldm r2,3  add r1,r2  sub r1,r2  and r2,r1  or r2,r1  mov r3,r2  add r3,r1  out r3
6820 0005 6840 0003 3a20 4220 4940 5140 3260 3960 2860
// 11: ldm r4,00f3  shl r4,4  shr r4,2  not r4  inc r4  out r4
6880 00f3 5884 6082 1080 1880 2880
// 18: ldm r5,40  std r4 to [r5]  ldd r6 from [r5]  inc r6 (load-use)  out r6
68a0 0040 7d80 75c0 18c0 28c0
// 24: ldm r7,1f  jz r7 (z clear)  sub r6,r6  jz r7 (taken)  out r1  out r2 (flushed)
68e0 001f 80e0 46c0 80e0 2820 2840
// 31: out r6
28c0
// 32: ldm r7,25  jmp r7  out r1  out r2 (flushed)
68e0 0025 88e0 2820 2840
// 37: in r0  out r0  setc  add r0,r0  out r0
2000 2800 0800 3800 2800
// 42: ldm r7,2c  jmp r7 onto itself, then padding
68e0 002c 88e0 0000 0000

/* sources.f */
design/cpu_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/processor.sv
bench/processor_tb.sv

/* Bender.yml */
package:
  name: processor

sources:
  - design/cpu_pkg.sv
  - design/fetch_stage.sv
  - design/decode_stage.sv
  - design/execute_stage.sv
  - design/memory_stage.sv
  - design/processor.sv
  - target: test
    files:
      - bench/processor_tb.sv
